/* Makefile */
TOP := rv_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f rv_core.f --Mdir obj_dir -o rv_core_sim
	out=$$(./obj_dir/rv_core_sim); echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

/* hdl/alu.sv */
// Integer ALU
module alu
    import rv_core_pkg::*;
(
    input  alu_op_e         i_op,
    input  logic [XLEN-1:0] i_src_a,
    input  logic [XLEN-1:0] i_src_b,
    output logic [XLEN-1:0] o_result,
    output logic            o_zero,
    output logic            o_lt,
    output logic            o_ltu
);

    logic [XLEN:0] diff;
    logic [4:0]    shamt;

    // Extra bit holds the borrow.
    assign diff  = {1'b0, i_src_a} - {1'b0, i_src_b};
    assign shamt = i_src_b[4:0];

    assign o_zero = (diff[XLEN-1:0] == '0);
    assign o_ltu  = diff[XLEN];
    assign o_lt   = (i_src_a[XLEN-1] != i_src_b[XLEN-1]) ? i_src_a[XLEN-1]
                                                         : diff[XLEN-1];

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_src_a + i_src_b;
            ALU_SUB:  o_result = diff[XLEN-1:0];
            ALU_AND:  o_result = i_src_a & i_src_b;
            ALU_OR:   o_result = i_src_a | i_src_b;
            ALU_XOR:  o_result = i_src_a ^ i_src_b;
            ALU_SLL:  o_result = i_src_a << shamt;
            ALU_SRL:  o_result = i_src_a >> shamt;
            ALU_SRA:  o_result = $signed(i_src_a) >>> shamt;
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, o_lt};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_ltu};
            default:  o_result = i_src_b;
        endcase
    end

endmodule

/* hdl/control_unit.sv */
// Multicycle control unit
module control_unit
    import rv_core_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  dp_status_t i_status,
    input  logic       i_mem_done,
    input  logic       i_misaligned,
    output dp_ctrl_t   o_ctrl,
    output logic       o_mem_valid,
    output logic       o_mem_we,
    output logic [2:0] o_mem_size
);

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXECUTE, S_MEM, S_WRITEBACK, S_TRAP
    } state_e;

    state_e      state_q, state_d;
    logic [3:0]  cause_q, cause_d;
    rv_instr_u   instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] csr_addr;
    logic        illegal;
    logic        taken;
    logic        is_jump;
    alu_op_e     arith_op;
    csr_sel_e    csr_sel;

    assign instr    = i_status.instr;
    assign opcode   = instr.r.opcode;
    assign funct3   = instr.r.funct3;
    assign funct7   = instr.r.funct7;
    assign csr_addr = {instr.r.funct7, instr.r.rs2};
    assign is_jump  = (opcode == OP_JAL) || (opcode == OP_JALR);

    // --------------------
    // Decoder.
    // --------------------
    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC, OP_JAL: illegal = 1'b0;
            OP_JALR:   illegal = (funct3 != 3'b000);
            OP_BRANCH: illegal = (funct3[2:1] == 2'b01);
            OP_LOAD:   illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            OP_STORE:  illegal = (funct3 > 3'b010);
            OP_IMM:    illegal = ((funct3 == 3'b001) && (funct7 != F7_ZERO)) ||
                                 ((funct3 == 3'b101) && (funct7 != F7_ZERO) &&
                                  (funct7 != F7_ALT));
            OP_OP:     illegal = !((funct7 == F7_ZERO) || ((funct7 == F7_ALT) &&
                                   ((funct3 == 3'b000) || (funct3 == 3'b101))));
            // Only CSRRS rd, csr, x0 is accepted.
            OP_SYSTEM: illegal = !((funct3 == 3'b010) && (instr.r.rs1 == 5'd0) &&
                                   ((csr_addr == CSR_ADDR_MEPC) ||
                                    (csr_addr == CSR_ADDR_MCAUSE) ||
                                    (csr_addr == CSR_ADDR_MTVEC)));
            default:   illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OP_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  taken = i_status.zero;
            3'b001:  taken = !i_status.zero;
            3'b100:  taken = i_status.lt;
            3'b101:  taken = !i_status.lt;
            3'b110:  taken = i_status.ltu;
            default: taken = !i_status.ltu;
        endcase
    end

    always_comb begin
        case (csr_addr)
            CSR_ADDR_MEPC:   csr_sel = CSR_MEPC;
            CSR_ADDR_MCAUSE: csr_sel = CSR_MCAUSE;
            default:         csr_sel = CSR_MTVEC;
        endcase
    end

    // --------------------
    // State machine.
    // --------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_FETCH;
            cause_q <= '0;
        end else begin
            state_q <= state_d;
            cause_q <= cause_d;
        end
    end

    always_comb begin
        o_ctrl         = '0;
        o_ctrl.csr_sel = csr_sel;
        o_ctrl.cause   = cause_q;
        o_mem_valid    = 1'b0;
        o_mem_we       = 1'b0;
        o_mem_size     = funct3;
        state_d        = state_q;
        cause_d        = cause_q;

        case (state_q)
            S_FETCH: begin
                // PC + 4 is ready on the result bus when the word arrives.
                o_mem_valid       = 1'b1;
                o_mem_size        = 3'b010;
                o_ctrl.fetch      = 1'b1;
                o_ctrl.src_b      = SRC_B_FOUR;
                o_ctrl.result_sel = RES_ALU;
                if (i_mem_done) begin
                    o_ctrl.pc_we     = 1'b1;
                    o_ctrl.ir_we     = 1'b1;
                    o_ctrl.old_pc_we = 1'b1;
                    state_d          = S_DECODE;
                end
            end
            S_DECODE: begin
                // Branch or JAL target into the ALU result register.
                o_ctrl.src_a   = SRC_A_OLD_PC;
                o_ctrl.src_b   = SRC_B_IMM;
                o_ctrl.imm_sel = (opcode == OP_JAL) ? IMM_J : IMM_B;
                state_d        = S_EXECUTE;
                if (illegal) begin
                    state_d = S_TRAP;
                    cause_d = CAUSE_ILLEGAL;
                end
            end
            S_EXECUTE: begin
                state_d = S_WRITEBACK;
                case (opcode)
                    OP_OP: begin
                        o_ctrl.src_a  = SRC_A_REG;
                        o_ctrl.alu_op = arith_op;
                    end
                    OP_IMM: begin
                        o_ctrl.src_a  = SRC_A_REG;
                        o_ctrl.src_b  = SRC_B_IMM;
                        o_ctrl.alu_op = arith_op;
                    end
                    OP_LUI: begin
                        o_ctrl.src_b   = SRC_B_IMM;
                        o_ctrl.imm_sel = IMM_U;
                        o_ctrl.alu_op  = ALU_PASS_B;
                    end
                    OP_AUIPC: begin
                        o_ctrl.src_a   = SRC_A_OLD_PC;
                        o_ctrl.src_b   = SRC_B_IMM;
                        o_ctrl.imm_sel = IMM_U;
                    end
                    OP_LOAD, OP_STORE: begin
                        o_ctrl.src_a   = SRC_A_REG;
                        o_ctrl.src_b   = SRC_B_IMM;
                        o_ctrl.imm_sel = (opcode == OP_STORE) ? IMM_S : IMM_I;
                        state_d        = S_MEM;
                    end
                    OP_JAL: begin
                        o_ctrl.pc_we = 1'b1;
                    end
                    OP_JALR: begin
                        o_ctrl.src_a      = SRC_A_REG;
                        o_ctrl.src_b      = SRC_B_IMM;
                        o_ctrl.result_sel = RES_ALU;
                        o_ctrl.pc_we      = 1'b1;
                    end
                    OP_BRANCH: begin
                        o_ctrl.src_a  = SRC_A_REG;
                        o_ctrl.alu_op = ALU_SUB;
                        o_ctrl.pc_we  = taken;
                    end
                    default: begin
                        o_ctrl.alu_op = ALU_ADD;
                    end
                endcase
            end
            S_MEM: begin
                // Same address every cycle, so the ALU result register holds it.
                o_ctrl.src_a   = SRC_A_REG;
                o_ctrl.src_b   = SRC_B_IMM;
                o_ctrl.imm_sel = (opcode == OP_STORE) ? IMM_S : IMM_I;
                o_mem_valid    = 1'b1;
                o_mem_we       = (opcode == OP_STORE);
                if (i_misaligned) begin
                    state_d = S_TRAP;
                    cause_d = (opcode == OP_STORE) ? CAUSE_STORE_MISALIGNED
                                                   : CAUSE_LOAD_MISALIGNED;
                end else if (i_mem_done) begin
                    o_ctrl.mdr_we = (opcode == OP_LOAD);
                    state_d       = (opcode == OP_STORE) ? S_FETCH : S_WRITEBACK;
                end
            end
            S_WRITEBACK: begin
                // Link value is old PC + 4.
                o_ctrl.src_a = SRC_A_OLD_PC;
                o_ctrl.src_b = SRC_B_FOUR;
                o_ctrl.rf_we = (opcode != OP_BRANCH);
                state_d      = S_FETCH;
                case (opcode)
                    OP_JAL, OP_JALR: o_ctrl.result_sel = RES_ALU;
                    OP_LOAD:         o_ctrl.result_sel = RES_LOAD;
                    OP_SYSTEM:       o_ctrl.result_sel = RES_CSR;
                    default:         o_ctrl.result_sel = RES_ALU_REG;
                endcase
                // New PC already written, check its alignment.
                if ((is_jump || opcode == OP_BRANCH) && (i_status.pc_lo != 2'b00)) begin
                    o_ctrl.rf_we = 1'b0;
                    state_d      = S_TRAP;
                    cause_d      = CAUSE_FETCH_MISALIGNED;
                end
            end
            default: begin
                o_ctrl.epc_we     = 1'b1;
                o_ctrl.cause_we   = 1'b1;
                o_ctrl.pc_we      = 1'b1;
                o_ctrl.result_sel = RES_TRAP;
                state_d           = S_FETCH;
            end
        endcase
    end

endmodule

/* hdl/datapath.sv */
// Multicycle datapath
module datapath
    import rv_core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC    = '0,
    parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h40
)(
    input  logic            clk,
    input  logic            i_rst_n,
    input  dp_ctrl_t        i_ctrl,
    input  logic [XLEN-1:0] i_load_data,
    output dp_status_t      o_status,
    output logic [XLEN-1:0] o_addr,
    output logic [XLEN-1:0] o_store_data
);

    // Nonarchitectural registers.
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] old_pc_q;
    rv_instr_u       ir_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;
    logic [XLEN-1:0] alu_q;
    logic [XLEN-1:0] mdr_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    logic [XLEN-1:0] rdata_1;
    logic [XLEN-1:0] rdata_2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] result;

    // --------------------
    // Registers.
    // --------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q     <= RESET_PC;
            mepc_q   <= '0;
            mcause_q <= '0;
        end else begin
            // Bit 0 always cleared, as JALR requires.
            if (i_ctrl.pc_we) begin
                pc_q <= {result[XLEN-1:1], 1'b0};
            end
            if (i_ctrl.epc_we) begin
                mepc_q <= old_pc_q;
            end
            if (i_ctrl.cause_we) begin
                mcause_q <= {{(XLEN-4){1'b0}}, i_ctrl.cause};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_ctrl.old_pc_we) begin
            old_pc_q <= pc_q;
        end
        if (i_ctrl.ir_we) begin
            ir_q <= i_load_data;
        end
        if (i_ctrl.mdr_we) begin
            mdr_q <= i_load_data;
        end
        a_q   <= rdata_1;
        b_q   <= rdata_2;
        alu_q <= alu_out;
    end

    // --------------------
    // Multiplexers.
    // --------------------
    always_comb begin
        case (i_ctrl.src_a)
            SRC_A_PC:     src_a = pc_q;
            SRC_A_OLD_PC: src_a = old_pc_q;
            default:      src_a = a_q;
        endcase
        case (i_ctrl.src_b)
            SRC_B_REG:  src_b = b_q;
            SRC_B_IMM:  src_b = imm;
            default:    src_b = 32'd4;
        endcase
        case (i_ctrl.csr_sel)
            CSR_MEPC:   csr_rdata = mepc_q;
            CSR_MCAUSE: csr_rdata = mcause_q;
            default:    csr_rdata = TRAP_VECTOR;
        endcase
        case (i_ctrl.result_sel)
            RES_ALU_REG: result = alu_q;
            RES_LOAD:    result = mdr_q;
            RES_ALU:     result = alu_out;
            RES_CSR:     result = csr_rdata;
            default:     result = TRAP_VECTOR;
        endcase
    end

    assign o_addr       = i_ctrl.fetch ? pc_q : result;
    assign o_store_data = b_q;

    assign o_status.instr = ir_q;
    assign o_status.pc_lo = pc_q[1:0];

    register_file register_file_inst (
        .clk       ( clk            ),
        .i_rst_n   ( i_rst_n        ),
        .i_we      ( i_ctrl.rf_we   ),
        .i_addr_1  ( ir_q.r.rs1     ),
        .i_addr_2  ( ir_q.r.rs2     ),
        .i_addr_3  ( ir_q.r.rd      ),
        .i_wdata   ( result         ),
        .o_rdata_1 ( rdata_1        ),
        .o_rdata_2 ( rdata_2        )
    );

    alu alu_inst (
        .i_op     ( i_ctrl.alu_op ),
        .i_src_a  ( src_a         ),
        .i_src_b  ( src_b         ),
        .o_result ( alu_out       ),
        .o_zero   ( o_status.zero ),
        .o_lt     ( o_status.lt   ),
        .o_ltu    ( o_status.ltu  )
    );

    extend_imm extend_imm_inst (
        .i_sel   ( i_ctrl.imm_sel ),
        .i_instr ( ir_q           ),
        .o_imm   ( imm            )
    );

endmodule

/* hdl/extend_imm.sv */
// Immediate extender
module extend_imm
    import rv_core_pkg::*;
(
    input  imm_sel_e        i_sel,
    input  rv_instr_u       i_instr,
    output logic [XLEN-1:0] o_imm
);

    logic [31:0]  word;
    instr_store_t st;

    assign word = i_instr;
    assign st   = i_instr.s;

    always_comb begin
        case (i_sel)
            IMM_I: o_imm = {{20{word[31]}}, word[31:20]};
            IMM_S: o_imm = {{20{st.imm_hi[6]}}, st.imm_hi, st.imm_lo};
            IMM_B: o_imm = {{20{st.imm_hi[6]}}, st.imm_lo[0], st.imm_hi[5:0],
                            st.imm_lo[4:1], 1'b0};
            IMM_U: o_imm = {word[31:12], 12'b0};
            // J format.
            default: o_imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        endcase
    end

endmodule

/* hdl/register_file.sv */
// Integer register file
module register_file
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_we,
    input  logic [4:0]      i_addr_1,
    input  logic [4:0]      i_addr_2,
    input  logic [4:0]      i_addr_3,
    input  logic [XLEN-1:0] i_wdata,
    output logic [XLEN-1:0] o_rdata_1,
    output logic [XLEN-1:0] o_rdata_2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_addr_3 != 5'd0)) begin
            regs[i_addr_3] <= i_wdata;
        end
    end

    // x0 never written, so it reads zero.
    assign o_rdata_1 = regs[i_addr_1];
    assign o_rdata_2 = regs[i_addr_2];

endmodule

/* hdl/rv_core_pkg.sv */
// RV32I core shared definitions
package rv_core_pkg;

    localparam int XLEN = 32;

    // Major opcodes.
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Readable CSR addresses.
    localparam logic [11:0] CSR_ADDR_MTVEC  = 12'h305;
    localparam logic [11:0] CSR_ADDR_MEPC   = 12'h341;
    localparam logic [11:0] CSR_ADDR_MCAUSE = 12'h342;

    // Trap causes.
    localparam logic [3:0] CAUSE_FETCH_MISALIGNED = 4'd0;
    localparam logic [3:0] CAUSE_ILLEGAL          = 4'd2;
    localparam logic [3:0] CAUSE_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] CAUSE_STORE_MISALIGNED = 4'd6;

    // --------------------
    // Control encodings.
    // --------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;
    typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_REG} src_a_e;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} src_b_e;
    typedef enum logic [2:0] {RES_ALU_REG, RES_LOAD, RES_ALU, RES_CSR, RES_TRAP} result_e;
    typedef enum logic [1:0] {CSR_MEPC, CSR_MCAUSE, CSR_MTVEC} csr_sel_e;

    typedef struct packed {
        logic       pc_we;
        logic       ir_we;
        logic       old_pc_we;
        logic       rf_we;
        logic       mdr_we;
        logic       epc_we;
        logic       cause_we;
        logic       fetch;      // Bus address comes from PC.
        alu_op_e    alu_op;
        src_a_e     src_a;
        src_b_e     src_b;
        imm_sel_e   imm_sel;
        result_e    result_sel;
        csr_sel_e   csr_sel;
        logic [3:0] cause;
    } dp_ctrl_t;

    // --------------------
    // Instruction views.
    // --------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_reg_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_store_t;

    typedef union packed {
        instr_reg_t   r;
        instr_store_t s;
    } rv_instr_u;

    typedef struct packed {
        logic      zero;
        logic      lt;
        logic      ltu;
        rv_instr_u instr;
        logic [1:0] pc_lo;
    } dp_status_t;

    // --------------------
    // Memory and bus.
    // --------------------
    typedef struct packed {
        logic            valid;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [2:0]      size;   // Load/store funct3.
    } mem_req_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat_w;
        logic [3:0]      sel;
    } wb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] dat_r;
        logic            ack;
    } wb_rsp_t;

endpackage

/* hdl/rv_core_top.sv */
// RV32I multicycle core top level
module rv_core_top
    import rv_core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC    = '0,
    parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h40
)(
    input  logic    clk,
    input  logic    i_rst_n,
    output wb_req_t o_wb,
    input  wb_rsp_t i_wb
);

    dp_ctrl_t        s_ctrl;
    dp_status_t      s_status;
    mem_req_t        s_mem_req;
    logic            s_mem_done;
    logic            s_misaligned;
    logic [XLEN-1:0] s_load_data;
    logic [XLEN-1:0] s_addr;
    logic [XLEN-1:0] s_store_data;
    logic            s_mem_valid;
    logic            s_mem_we;
    logic [2:0]      s_mem_size;

    // Request fields from both sides.
    assign s_mem_req.valid = s_mem_valid;
    assign s_mem_req.we    = s_mem_we;
    assign s_mem_req.size  = s_mem_size;
    assign s_mem_req.addr  = s_addr;
    assign s_mem_req.wdata = s_store_data;

    control_unit control_unit_inst (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_status     ( s_status     ),
        .i_mem_done   ( s_mem_done   ),
        .i_misaligned ( s_misaligned ),
        .o_ctrl       ( s_ctrl       ),
        .o_mem_valid  ( s_mem_valid  ),
        .o_mem_we     ( s_mem_we     ),
        .o_mem_size   ( s_mem_size   )
    );

    datapath #(
        .RESET_PC    ( RESET_PC    ),
        .TRAP_VECTOR ( TRAP_VECTOR )
    ) datapath_inst (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_ctrl       ( s_ctrl       ),
        .i_load_data  ( s_load_data  ),
        .o_status     ( s_status     ),
        .o_addr       ( s_addr       ),
        .o_store_data ( s_store_data )
    );

    wb_mem_port wb_mem_port_inst (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_req        ( s_mem_req    ),
        .o_wb         ( o_wb         ),
        .i_wb         ( i_wb         ),
        .o_done       ( s_mem_done   ),
        .o_misaligned ( s_misaligned ),
        .o_load_data  ( s_load_data  )
    );

endmodule

/* hdl/wb_mem_port.sv */
// Wishbone classic memory port
module wb_mem_port
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst_n,
    input  mem_req_t        i_req,
    output wb_req_t         o_wb,
    input  wb_rsp_t         i_wb,
    output logic            o_done,
    output logic            o_misaligned,
    output logic [XLEN-1:0] o_load_data
);

    logic [1:0]      off;
    logic            hold_q;
    logic [XLEN-1:0] shifted;

    assign off = i_req.addr[1:0];

    assign o_misaligned = ((i_req.size[1:0] == 2'b01) && off[0]) ||
                          ((i_req.size[1:0] == 2'b10) && (off != 2'b00));

    // Bus idle for one cycle after reset and after each ack.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hold_q <= 1'b1;
        end else begin
            hold_q <= o_wb.cyc && i_wb.ack;
        end
    end

    assign o_wb.cyc = i_req.valid && !o_misaligned && !hold_q;
    assign o_wb.stb = o_wb.cyc;
    assign o_wb.we  = i_req.we;
    assign o_wb.adr = {i_req.addr[XLEN-1:2], 2'b00};
    assign o_done   = o_wb.cyc && i_wb.ack;

    // --------------------
    // Byte lanes.
    // --------------------
    always_comb begin
        case (i_req.size[1:0])
            2'b00: begin
                o_wb.sel   = 4'b0001 << off;
                o_wb.dat_w = {4{i_req.wdata[7:0]}};
            end
            2'b01: begin
                o_wb.sel   = 4'b0011 << off;
                o_wb.dat_w = {2{i_req.wdata[15:0]}};
            end
            default: begin
                o_wb.sel   = 4'b1111;
                o_wb.dat_w = i_req.wdata;
            end
        endcase
    end

    // Size bit 2 marks LBU and LHU.
    assign shifted = i_wb.dat_r >> {off, 3'b000};

    always_comb begin
        case (i_req.size[1:0])
            2'b00:   o_load_data = {{24{!i_req.size[2] && shifted[7]}}, shifted[7:0]};
            2'b01:   o_load_data = {{16{!i_req.size[2] && shifted[15]}}, shifted[15:0]};
            default: o_load_data = shifted;
        endcase
    end

endmodule

/* rv_core.f */
hdl/rv_core_pkg.sv
hdl/register_file.sv
hdl/alu.sv
hdl/extend_imm.sv
hdl/datapath.sv
hdl/control_unit.sv
hdl/wb_mem_port.sv
hdl/rv_core_top.sv
tests/clock_gen.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

/* tests/clock_gen.sv */
// Clock and reset generator
module clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
)(
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Release on a rising edge.
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

/* tests/rv_core_assertions.sv */
// Wishbone handshake assertions
module rv_core_assertions
    import rv_core_pkg::*;
(
    input logic    clk,
    input logic    i_rst_n,
    input wb_req_t i_wb_req,
    input wb_rsp_t i_wb_rsp
);

    // --------------------
    // Classic cycle rules.
    // --------------------
    a_stb_needs_cyc: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_wb_req.stb |-> i_wb_req.cyc
    ) else $error("stb high without cyc");

    // Request held until ack.
    a_req_stable: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (i_wb_req.stb && !i_wb_rsp.ack) |=>
            (i_wb_req.stb && $stable(i_wb_req.adr) && $stable(i_wb_req.dat_w) &&
             $stable(i_wb_req.sel) && $stable(i_wb_req.we))
    ) else $error("request changed before ack");

    // First cycle after the release edge stays idle.
    a_idle_after_reset: assert property (
        @(posedge clk) $rose(i_rst_n) |-> !i_wb_req.cyc
    ) else $error("cyc raised right after reset release");

endmodule

/* tests/rv_core_input.hex */
// Words 0 to 63: program image at address 0, trap handler at 0x40.
// Then pairs: expected store word address, memory word after the store.
12300093 // 00 addi x1, x0, 0x123
FFB00113 // 04 addi x2, x0, -5
002081B3 // 08 add x3, x1, x2
20302023 // 0C sw x3, 0x200
40208233 // 10 sub x4, x1, x2
20402023 // 14 sw x4, 0x200
0020C2B3 // 18 xor x5, x1, x2
20502023 // 1C sw x5, 0x200
00400313 // 20 addi x6, x0, 4
006093B3 // 24 sll x7, x1, x6
20702023 // 28 sw x7, 0x200
40615433 // 2C sra x8, x2, x6
20802023 // 30 sw x8, 0x200
0020B4B3 // 34 sltu x9, x1, x2
20902023 // 38 sw x9, 0x200
0240006F // 3C jal x0, 0x60
34202573 // 40 csrrs x10, mcause, x0
20A02023 // 44 sw x10, 0x200
341025F3 // 48 csrrs x11, mepc, x0
20B02023 // 4C sw x11, 0x200
00458593 // 50 addi x11, x11, 4
00058067 // 54 jalr x0, 0(x11)
00000000
00000000
89ABD637 // 60 lui x12, 0x89ABD
DEF60613 // 64 addi x12, x12, -0x211
20C02223 // 68 sw x12, 0x204
201002A3 // 6C sb x1, 0x205
20201323 // 70 sh x2, 0x206
20500683 // 74 lb x13, 0x205
20D02023 // 78 sw x13, 0x200
20704703 // 7C lbu x14, 0x207
20E02023 // 80 sw x14, 0x200
20601783 // 84 lh x15, 0x206
20F02023 // 88 sw x15, 0x200
20605803 // 8C lhu x16, 0x206
21002023 // 90 sw x16, 0x200
00208463 // 94 beq x1, x2, +8 not taken
20102023 // 98 sw x1, 0x200
00209463 // 9C bne x1, x2, +8 taken
20202023 // A0 sw x2 skipped
00114463 // A4 blt x2, x1, +8 taken
20202023 // A8 sw x2 skipped
00116463 // AC bltu x2, x1, +8 not taken
20302023 // B0 sw x3, 0x200
0080096F // B4 jal x18, +8
20202023 // B8 sw x2 skipped
21202023 // BC sw x18, 0x200
0D000993 // C0 addi x19, x0, 0xD0
00098A67 // C4 jalr x20, 0(x19)
20202023 // C8 sw x2 skipped
20202023 // CC sw x2 skipped
21402023 // D0 sw x20, 0x200
00001A97 // D4 auipc x21, 1
21502023 // D8 sw x21, 0x200
FFFFFFFF // DC illegal
20202B03 // E0 lw x22, 0x202 misaligned
0E102E23 // E4 sw x1, 0xFC end marker
0000006F // E8 jal x0, 0
00000000
00000000
00000000
00000000
00000000
00000200 0000011E
00000200 00000128
00000200 FFFFFED8
00000200 00001230
00000200 FFFFFFFF
00000200 00000001
00000204 89ABCDEF
00000204 89AB23EF
00000204 FFFB23EF
00000200 00000023
00000200 000000FF
00000200 FFFFFFFB
00000200 0000FFFB
00000200 00000123
00000200 0000011E
00000200 000000B8
00000200 000000C8
00000200 000010D4
00000200 00000002
00000200 000000DC
00000200 00000004
00000200 000000E0
000000FC 00000123

/* tests/rv_core_tb.sv */
// RV32I core testbench
module rv_core_tb
    import rv_core_pkg::*;
();

    localparam int          PROG_WORDS     = 64;
    localparam int          STORE_COUNT    = 23;
    localparam int          IMAGE_WORDS    = PROG_WORDS + 2 * STORE_COUNT;
    localparam int          MEM_WORDS      = 256;
    localparam int          TIMEOUT_CYCLES = 200 * PROG_WORDS;
    localparam logic [31:0] END_ADDR       = 32'hFC;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    logic [31:0] image [0:IMAGE_WORDS-1];
    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] lfsr;
    logic        in_access;
    int          waits_left;
    int          store_idx;
    int          errors;
    logic        done;

    clock_gen #(
        .PERIOD       ( 8 ),
        .RESET_CYCLES ( 4 )
    ) clock_gen_inst (
        .o_clk   ( clk   ),
        .o_rst_n ( rst_n )
    );

    rv_core_top #(
        .RESET_PC    ( 32'h0  ),
        .TRAP_VECTOR ( 32'h40 )
    ) rv_core_top_inst (
        .clk     ( clk    ),
        .i_rst_n ( rst_n  ),
        .o_wb    ( wb_req ),
        .i_wb    ( wb_rsp )
    );

    bind rv_core_top rv_core_assertions rv_core_assertions_inst (
        .clk      ( clk     ),
        .i_rst_n  ( i_rst_n ),
        .i_wb_req ( o_wb    ),
        .i_wb_rsp ( i_wb    )
    );

    // --------------------
    // Helpers.
    // --------------------
    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_wait(output int n);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr    = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
        n = bits;
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] word);
        logic [31:0] exp_addr;
        logic [31:0] exp_word;
        if (store_idx >= STORE_COUNT) begin
            $display("Unexpected extra store to address %h", addr);
            errors++;
        end else begin
            exp_addr = image[PROG_WORDS + 2 * store_idx];
            exp_word = image[PROG_WORDS + 2 * store_idx + 1];
            if (addr != exp_addr) begin
                $display("** Error: store %0d wb adr expected %h got %h",
                         store_idx, exp_addr, addr);
                errors++;
            end
            if (word != exp_word) begin
                $display("** Error: store %0d memory word expected %h got %h",
                         store_idx, exp_word, word);
                errors++;
            end
        end
        store_idx++;
        if (addr == END_ADDR) begin
            done = 1'b1;
        end
    endtask

    // --------------------
    // Memory model.
    // --------------------
    initial begin
        wb_rsp     = '0;
        lfsr       = 32'h389a;
        in_access  = 1'b0;
        waits_left = 0;
        store_idx  = 0;
        errors     = 0;
        done       = 1'b0;
        $readmemh("tests/rv_core_input.hex", image);
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < PROG_WORDS) begin
                mem[i] = image[i];
            end else begin
                mem[i] = {8'hA5, i[7:0], ~i[7:0], i[7:0] ^ 8'h3C};
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            wb_rsp.ack <= 1'b0;
            in_access = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!in_access) begin
                in_access = 1'b1;
                draw_wait(waits_left);
            end
            if (waits_left == 0) begin
                in_access = 1'b0;
                if (wb_req.adr >= 4 * MEM_WORDS) begin
                    $display("Bus access outside memory at %h", wb_req.adr);
                    errors++;
                end else if (wb_req.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_req.sel[b]) begin
                            mem[wb_req.adr[9:2]][8*b +: 8] = wb_req.dat_w[8*b +: 8];
                        end
                    end
                    check_store(wb_req.adr, mem[wb_req.adr[9:2]]);
                end else begin
                    wb_rsp.dat_r <= mem[wb_req.adr[9:2]];
                end
                wb_rsp.ack <= 1'b1;
            end else begin
                waits_left--;
            end
        end
    end

    // --------------------
    // Run control.
    // --------------------
    initial begin
        wait (done);
        @(posedge clk);
        if (store_idx != STORE_COUNT) begin
            $display("Store count wrong, %0d seen, %0d expected", store_idx, STORE_COUNT);
            errors++;
        end
        $display("Errors: %0d, stores checked: %0d", errors, store_idx);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout, the end store was not seen after %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d, stores checked: %0d", errors, store_idx);
        $display("Test failed");
        $finish;
    end

endmodule
